// ==== sim.f ====
+incdir+include
logic/rv_isa_pkg.sv
logic/ctrl_pkg.sv
logic/ctrl_if.sv
logic/insn_dispatch.sv
logic/fsm_alu.sv
logic/fsm_branch_jump.sv
logic/fsm_load_store.sv
logic/fsm_fp_op.sv
logic/fsm_combined.sv
logic/control_unit.sv
test/control_unit_tb.sv

// ==== test/control_unit_golden.txt ====
// insn     lu ls eq mlat flat unit sel_rd taken wb fp sub alt
// unit 0 illegal, 1 alu, 2 branch, 3 mem, 4 fp. alt is store for mem, fmul for fp.
002081B3 0 0 0 0 0 1 2 0 1 0 0 0 // add x3, x1, x2
407302B3 0 0 0 0 0 1 2 0 1 0 1 0 // sub x5, x6, x7
00500093 0 0 0 0 0 1 2 0 1 0 0 0 // addi x1, x0, 5
40325213 0 0 0 0 0 1 2 0 1 0 1 0 // srai x4, x4, 3
FFF10113 0 0 0 0 0 1 2 0 1 0 0 0 // addi x2, x2, -1
00208063 0 0 1 0 0 2 3 1 0 0 0 0 // beq, equal
00208063 0 0 0 0 0 2 3 0 0 0 0 0 // beq, not equal
00209063 0 0 1 0 0 2 3 0 0 0 0 0 // bne, equal
0020C063 0 1 0 0 0 2 3 1 0 0 0 0 // blt, less
0020D063 0 1 0 0 0 2 3 0 0 0 0 0 // bge, less
0020E063 0 0 0 0 0 2 3 0 0 0 0 0 // bltu, not less
0020F063 0 0 0 0 0 2 3 1 0 0 0 0 // bgeu, not less
000000EF 0 0 0 0 0 2 3 1 1 0 0 0 // jal x1
000280E7 1 1 0 0 0 2 3 1 1 0 0 0 // jalr x1, 0(x5)
0000A183 0 0 0 2 0 3 1 0 1 0 0 0 // lw x3, 0(x1)
0080A183 0 0 0 5 0 3 1 0 1 0 0 0 // lw x3, 8(x1)
0020A223 0 0 0 1 0 3 1 0 0 0 0 1 // sw x2, 4(x1)
0000A087 0 0 0 3 0 3 1 0 0 1 0 0 // flw f1, 0(x1)
0020A027 0 0 0 4 0 3 1 0 0 1 0 1 // fsw f2, 0(x1)
002081D3 0 0 0 0 3 4 0 0 0 1 0 0 // fadd.s f3, f1, f2
082081D3 0 0 0 0 1 4 0 0 0 1 1 0 // fsub.s f3, f1, f2
102081D3 0 0 0 0 6 4 0 0 0 1 0 1 // fmul.s f3, f1, f2
0000007F 0 0 0 0 0 0 0 0 0 0 0 0 // unknown opcode
002081B3 0 0 0 0 0 1 2 0 1 0 0 0 // add after an illegal word
00000000 0 0 0 0 0 0 0 0 0 0 0 0 // all zero word
0020C063 1 0 1 0 0 2 3 0 0 0 0 0 // blt, not less

// ==== test/control_unit_tb.sv ====
`timescale 1ns/100ps

module control_unit_tb;
    localparam int NF        = 13; // hex fields per golden line.
    localparam int MAX_LINES = 64;

    logic        clk;
    logic        arst_n;
    logic        issue;
    logic [31:0] insn;
    logic        lu, ls, eq;
    logic        memory_done;
    logic        done_fp;
    logic [1:0]  sel_rd;
    logic sub_sra, sel_pc_next, sel_alu_a, sel_alu_b, sel_alu_32b;
    logic load_pc_alu, load_flags, sel_pc_increment, sel_pc_jump;
    logic load_pc, load_regfile, load_rs1, load_rs2, load_imm, load_alu;
    logic load_fp_regfile, load_rs1_fp, load_rs2_fp, sel_store_fp, sel_rd_fp;
    logic start_add_sub_fp, start_mult_fp, load_alu_fp, sub_fp;
    logic load_data_memory, memory_start, sel_mem_next, sel_mem_operation;
    logic done;
    logic illegal_insn;

    logic [30:0] ctrl_word;
    logic [31:0] golden [0:NF*MAX_LINES-1];
    logic [31:0] g_insn, g_lu, g_ls, g_eq, g_mem_lat, g_fp_lat;
    logic [31:0] g_unit, g_sel_rd, g_taken, g_wb, g_fp, g_sub, g_alt;

    int n_lines;
    int n_legal;
    int line_idx;
    int cyc;
    int gap;
    int n_checks;
    int n_errors;
    int done_count;
    int cycle_count;
    int cycle_limit;

    control_unit u_dut (.*);

    assign ctrl_word = {sel_rd, sub_sra, sel_pc_next, sel_alu_a, sel_alu_b, sel_alu_32b,
                        load_pc_alu, load_flags, sel_pc_increment, sel_pc_jump,
                        load_pc, load_regfile, load_rs1, load_rs2, load_imm, load_alu,
                        load_fp_regfile, load_rs1_fp, load_rs2_fp, sel_store_fp, sel_rd_fp,
                        start_add_sub_fp, start_mult_fp, load_alu_fp, sub_fp,
                        load_data_memory, memory_start, sel_mem_next, sel_mem_operation,
                        done};

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (arst_n && done)
            done_count++;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("checks run: %0d, errors: %0d", n_checks, n_errors);
            $display("Test failures found");
            $finish;
        end
    end

    // ####################################################################
    // helpers
    // ####################################################################

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        n_checks++;
        assert (got === exp)
            else begin
                n_errors++;
                $display("FAILED %s: line %0d cycle %0d got 0x%0h, expected 0x%0h",
                         name, line_idx, cyc, got, exp);
            end
    endtask

    task automatic load_line(input int idx);
        int base;
        base      = idx * NF;
        g_insn    = golden[base];
        g_lu      = golden[base + 1];
        g_ls      = golden[base + 2];
        g_eq      = golden[base + 3];
        g_mem_lat = golden[base + 4];
        g_fp_lat  = golden[base + 5];
        g_unit    = golden[base + 6];
        g_sel_rd  = golden[base + 7];
        g_taken   = golden[base + 8];
        g_wb      = golden[base + 9];
        g_fp      = golden[base + 10];
        g_sub     = golden[base + 11];
        g_alt     = golden[base + 12];
    endtask

    // one instruction from issue (C0) to its done cycle.
    task automatic run_insn();
        int   exp_done;
        int   fp_resp;
        int   mem_resp;
        logic finished;
        exp_done = (g_unit == 1 || g_unit == 2) ? 4 : -1; // mem and fp wait on a reply.
        fp_resp  = -1;
        mem_resp = -1;
        finished = 1'b0;
        @(posedge clk);
        #1;
        issue = 1'b1;
        insn  = g_insn;
        lu    = g_lu[0];
        ls    = g_ls[0];
        eq    = g_eq[0];
        cyc   = 0;
        @(negedge clk);
        check_val("ctrl_word", ctrl_word, '0);
        @(posedge clk);
        #1;
        issue = 1'b0;
        cyc   = 1;
        @(negedge clk);
        check_val("illegal_insn", illegal_insn, g_unit == 0);
        check_val("ctrl_word", ctrl_word, '0); // combiner latches on the edge ending C1.
        if (g_unit == 0) begin
            repeat (3) begin
                @(posedge clk);
                #1;
                cyc++;
                @(negedge clk);
                check_val("illegal_insn", illegal_insn, 0);
                check_val("ctrl_word", ctrl_word, '0);
            end
        end else begin
            while (!finished) begin
                @(posedge clk);
                #1;
                cyc++;
                memory_done = (cyc == mem_resp);
                done_fp     = (cyc == fp_resp);
                @(negedge clk);
                case (g_unit)
                    1: if (cyc == 3)
                        check_val("sub_sra", sub_sra, g_sub);
                    3: begin
                        check_val("memory_start", memory_start, cyc == 4);
                        if (cyc == 4) begin
                            mem_resp = cyc + g_mem_lat;
                            exp_done = mem_resp + 1;
                            check_val("sel_mem_operation", sel_mem_operation, g_alt);
                            check_val("sel_store_fp", sel_store_fp, g_fp[0] & g_alt[0]);
                        end
                    end
                    4: begin
                        if (cyc == 3) begin
                            fp_resp  = cyc + g_fp_lat;
                            exp_done = fp_resp + 2;
                            check_val("start_mult_fp", start_mult_fp, g_alt);
                            check_val("start_add_sub_fp", start_add_sub_fp, !g_alt[0]);
                            check_val("sub_fp", sub_fp, g_sub);
                        end
                        if (fp_resp > 0)
                            check_val("load_alu_fp", load_alu_fp, cyc == fp_resp + 1);
                    end
                    default: ;
                endcase
                check_val("done", done, cyc == exp_done);
                if (done || cyc == exp_done) begin
                    check_val("sel_rd", sel_rd, g_sel_rd);
                    check_val("sel_pc_jump", sel_pc_jump, g_taken);
                    check_val("load_regfile", load_regfile, g_wb);
                    check_val("load_fp_regfile", load_fp_regfile,
                              g_fp[0] & !(g_unit == 3 && g_alt[0])); // fsw writes no register.
                    check_val("load_pc", load_pc, 1);
                    finished = 1'b1;
                end
            end
        end
    endtask

    // ####################################################################
    // main sequence
    // ####################################################################

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        issue       = 1'b0;
        insn        = '0;
        lu          = 1'b0;
        ls          = 1'b0;
        eq          = 1'b0;
        memory_done = 1'b0;
        done_fp     = 1'b0;
        cycle_limit = 100000;
        cyc         = -1;
        void'($urandom(42));

        $readmemh("test/control_unit_golden.txt", golden);
        while (n_lines < MAX_LINES && !$isunknown(golden[n_lines * NF]))
            n_lines++;
        for (int i = 0; i < n_lines; i++) begin
            if (golden[i * NF + 6] != 0)
                n_legal++;
        end
        if (n_lines == 0) begin
            n_errors++;
            $display("golden file holds no instructions");
        end
        cycle_limit = 30 * n_lines + 8;

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_val("ctrl_word", ctrl_word, '0); // during reset.
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_val("ctrl_word", ctrl_word, '0);
        check_val("illegal_insn", illegal_insn, 0);

        for (line_idx = 0; line_idx < n_lines; line_idx++) begin
            load_line(line_idx);
            run_insn();
            gap = $urandom % 4;
            cyc = -1;
            repeat (gap) begin
                @(posedge clk);
                #1;
                @(negedge clk);
                check_val("ctrl_word", ctrl_word, '0);
            end
        end

        repeat (2) @(posedge clk);
        check_val("done pulse count", done_count, n_legal);
        $display("checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module control_unit import rv_isa_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue,
    input  logic [`XLEN-1:0]  insn,
    input  logic              lu,
    input  logic              ls,
    input  logic              eq,
    input  logic              memory_done,
    input  logic              done_fp,
    output logic [1:0]        sel_rd,
    output logic sub_sra, sel_pc_next, sel_alu_a, sel_alu_b, sel_alu_32b,
    output logic load_pc_alu, load_flags, sel_pc_increment, sel_pc_jump,
    output logic load_pc, load_regfile, load_rs1, load_rs2, load_imm, load_alu,
    output logic load_fp_regfile, load_rs1_fp, load_rs2_fp, sel_store_fp, sel_rd_fp,
    output logic start_add_sub_fp, start_mult_fp, load_alu_fp, sub_fp,
    output logic load_data_memory, memory_start, sel_mem_next, sel_mem_operation,
    output logic done,
    output logic illegal_insn
);
    rv_insn_u            insn_q;
    logic [`N_UNITS-1:0] start;

    ctrl_if alu_c ();
    ctrl_if br_c ();
    ctrl_if mem_c ();
    ctrl_if fp_c ();

    insn_dispatch u_dispatch (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue        (issue),
        .insn         (insn),
        .insn_q       (insn_q),
        .start        (start),
        .illegal_insn (illegal_insn)
    );

    // ####################################################################
    // sequencers in the start bit order of the dispatcher decode.
    // ####################################################################

    fsm_alu u_alu (.clk, .arst_n, .start(start[0]), .insn_q, .ctrl(alu_c));

    fsm_branch_jump u_branch (
        .clk, .arst_n, .start(start[1]), .insn_q, .lu, .ls, .eq, .ctrl(br_c)
    );

    fsm_load_store u_mem (
        .clk, .arst_n, .start(start[2]), .insn_q, .memory_done, .ctrl(mem_c)
    );

    fsm_fp_op u_fp (.clk, .arst_n, .start(start[3]), .insn_q, .done_fp, .ctrl(fp_c));

    fsm_combined u_comb (.*);

endmodule

// ==== logic/fsm_combined.sv ====
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module fsm_combined import ctrl_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [`N_UNITS-1:0] start,
    ctrl_if.mux                 alu_c,
    ctrl_if.mux                 br_c,
    ctrl_if.mux                 mem_c,
    ctrl_if.mux                 fp_c,
    output logic [1:0]          sel_rd,
    output logic sub_sra, sel_pc_next, sel_alu_a, sel_alu_b, sel_alu_32b,
    output logic load_pc_alu, load_flags, sel_pc_increment, sel_pc_jump,
    output logic load_pc, load_regfile, load_rs1, load_rs2, load_imm, load_alu,
    output logic load_fp_regfile, load_rs1_fp, load_rs2_fp, sel_store_fp, sel_rd_fp,
    output logic start_add_sub_fp, start_mult_fp, load_alu_fp, sub_fp,
    output logic load_data_memory, memory_start, sel_mem_next, sel_mem_operation,
    output logic done
);
    unit_e              unit;
    logic [`CTRL_W-1:0] word;

    // ####################################################################
    // active unit.
    // ####################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            unit <= UNIT_IDLE;
        end else begin
            if (start[0])
                unit <= UNIT_ALU;
            else if (start[1])
                unit <= UNIT_BRANCH;
            else if (start[2])
                unit <= UNIT_MEM;
            else if (start[3])
                unit <= UNIT_FP;
            else if (done)
                unit <= UNIT_IDLE; // back to idle after the last cycle.
        end
    end

    // ####################################################################
    // control word select.
    // ####################################################################

    always_comb begin
        case (unit)
            UNIT_ALU:    word = alu_c.word;
            UNIT_BRANCH: word = br_c.word;
            UNIT_MEM:    word = mem_c.word;
            UNIT_FP:     word = fp_c.word;
            default:     word = '0; // idle word leaves sel_rd at fp_move.
        endcase
    end

    assign {sel_rd, sub_sra, sel_pc_next, sel_alu_a, sel_alu_b, sel_alu_32b,
            load_pc_alu, load_flags, sel_pc_increment, sel_pc_jump,
            load_pc, load_regfile, load_rs1, load_rs2, load_imm, load_alu,
            load_fp_regfile, load_rs1_fp, load_rs2_fp, sel_store_fp, sel_rd_fp,
            start_add_sub_fp, start_mult_fp, load_alu_fp, sub_fp,
            load_data_memory, memory_start, sel_mem_next, sel_mem_operation,
            done} = word;

    // an issue before the running sequence has finished.
    assert property (@(posedge clk) disable iff (!arst_n) (start != '0) |-> unit == UNIT_IDLE)
        else $error("fsm_combined: start while unit %0d active.", unit);

endmodule

// ==== logic/fsm_fp_op.sv ====
`timescale 1ns/100ps

module fsm_fp_op import rv_isa_pkg::*, ctrl_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,
    input  rv_insn_u insn_q,
    input  logic     done_fp,
    ctrl_if.fsm      ctrl
);
    typedef enum logic [2:0] {
        S_IDLE, S_OPERANDS, S_START, S_WAIT, S_RESULT, S_WRITE
    } state_e;

    state_e state;
    logic   is_mul;
    logic   is_sub;

    assign is_mul = (insn_q.r.funct7 == FP_MUL);
    assign is_sub = (insn_q.r.funct7 == FP_SUB);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:          state <= start ? S_OPERANDS : S_IDLE;
                S_OPERANDS:      state <= S_START;
                S_START, S_WAIT: state <= done_fp ? S_RESULT : S_WAIT;
                S_RESULT:        state <= S_WRITE;
                default:         state <= S_IDLE;
            endcase
        end
    end

    assign ctrl.sel_rd           = SEL_RD_FP_MOVE;
    assign ctrl.load_rs1_fp      = (state == S_OPERANDS);
    assign ctrl.load_rs2_fp      = (state == S_OPERANDS);
    assign ctrl.start_mult_fp    = (state == S_START) && is_mul;
    assign ctrl.start_add_sub_fp = (state == S_START) && !is_mul;
    assign ctrl.sub_fp           = ((state == S_START) || (state == S_WAIT)) && is_sub;
    assign ctrl.load_alu_fp      = (state == S_RESULT);
    assign ctrl.load_fp_regfile  = (state == S_WRITE);
    assign ctrl.load_pc          = (state == S_WRITE);
    assign ctrl.sel_pc_increment = (state == S_WRITE);
    assign ctrl.done             = (state == S_WRITE);

    assign {ctrl.sub_sra, ctrl.sel_pc_next, ctrl.sel_alu_a, ctrl.sel_alu_b,
            ctrl.sel_alu_32b, ctrl.load_pc_alu, ctrl.load_flags, ctrl.sel_pc_jump,
            ctrl.load_regfile, ctrl.load_rs1, ctrl.load_rs2, ctrl.load_imm,
            ctrl.load_alu, ctrl.sel_store_fp, ctrl.sel_rd_fp, ctrl.load_data_memory,
            ctrl.memory_start, ctrl.sel_mem_next, ctrl.sel_mem_operation} = '0;

    assert property (@(posedge clk) disable iff (!arst_n) ctrl.done |=> !ctrl.done)
        else $error("fsm_fp_op: done longer than one cycle.");

endmodule

// ==== logic/fsm_load_store.sv ====
`timescale 1ns/100ps

module fsm_load_store import rv_isa_pkg::*, ctrl_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,
    input  rv_insn_u insn_q,
    input  logic     memory_done,
    ctrl_if.fsm      ctrl
);
    typedef enum logic [2:0] {
        S_IDLE, S_OPERANDS, S_ADDR, S_MEM_REQ, S_MEM_WAIT, S_FINISH
    } state_e;

    state_e state;
    logic   is_store;
    logic   is_flw;
    logic   is_fsw;
    logic   has_offset;
    logic   in_access;

    assign is_flw   = (insn_q.r.opcode == OPC_FLW);
    assign is_fsw   = (insn_q.s.opcode == OPC_FSW);
    assign is_store = is_fsw || (insn_q.s.opcode == OPC_STORE);

    // store offset is split around rs2 and rs1, a load offset is contiguous.
    assign has_offset = is_store ? |{insn_q.s.imm_hi, insn_q.s.imm_lo}
                                 : |{insn_q.r.funct7, insn_q.r.rs2};
    assign in_access  = (state == S_MEM_REQ) || (state == S_MEM_WAIT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:                state <= start ? S_OPERANDS : S_IDLE;
                S_OPERANDS:            state <= S_ADDR;
                S_ADDR:                state <= S_MEM_REQ;
                S_MEM_REQ, S_MEM_WAIT: state <= memory_done ? S_FINISH : S_MEM_WAIT;
                default:               state <= S_IDLE;
            endcase
        end
    end

    assign ctrl.sel_rd            = SEL_RD_MEM;
    assign ctrl.load_rs1          = (state == S_OPERANDS);
    assign ctrl.load_rs2          = (state == S_OPERANDS) && !is_fsw;
    assign ctrl.load_rs2_fp       = (state == S_OPERANDS) && is_fsw; // fp store data.
    assign ctrl.load_imm          = (state == S_OPERANDS);
    assign ctrl.load_alu          = (state == S_ADDR);
    assign ctrl.sel_alu_b         = (state == S_ADDR);
    assign ctrl.memory_start      = (state == S_MEM_REQ);
    assign ctrl.sel_mem_next      = in_access && has_offset; // else address is rs1.
    assign ctrl.sel_mem_operation = in_access && is_store;
    assign ctrl.sel_store_fp      = in_access && is_fsw;
    assign ctrl.load_pc           = (state == S_FINISH);
    assign ctrl.sel_pc_increment  = (state == S_FINISH);
    assign ctrl.done              = (state == S_FINISH);
    assign ctrl.load_data_memory  = (state == S_FINISH) && !is_store;
    assign ctrl.load_regfile      = (state == S_FINISH) && !is_store && !is_flw;
    assign ctrl.load_fp_regfile   = (state == S_FINISH) && is_flw;
    assign ctrl.sel_rd_fp         = (state == S_FINISH) && is_flw;

    assign {ctrl.sub_sra, ctrl.sel_alu_a, ctrl.sel_alu_32b, ctrl.load_pc_alu,
            ctrl.load_flags, ctrl.sel_pc_next, ctrl.sel_pc_jump, ctrl.load_rs1_fp,
            ctrl.start_add_sub_fp, ctrl.start_mult_fp, ctrl.load_alu_fp,
            ctrl.sub_fp} = '0;

    assert property (@(posedge clk) disable iff (!arst_n) ctrl.done |=> !ctrl.done)
        else $error("fsm_load_store: done longer than one cycle.");

endmodule

// ==== logic/fsm_branch_jump.sv ====
`timescale 1ns/100ps

module fsm_branch_jump import rv_isa_pkg::*, ctrl_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,
    input  rv_insn_u insn_q,
    input  logic     lu,
    input  logic     ls,
    input  logic     eq,
    ctrl_if.fsm      ctrl
);
    typedef enum logic [1:0] {S_IDLE, S_OPERANDS, S_FLAGS, S_UPDATE} state_e;

    state_e state;
    logic   is_jalr;
    logic   is_jump;
    logic   taken;

    assign is_jalr = (insn_q.r.opcode == OPC_JALR);
    assign is_jump = is_jalr || (insn_q.r.opcode == OPC_JAL);

    always_comb begin
        case (branch_funct_e'(insn_q.r.funct3))
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = ls;
            BR_BGE:  taken = !ls;
            BR_BLTU: taken = lu;
            BR_BGEU: taken = !lu;
            default: taken = 1'b0;
        endcase
        if (is_jump)
            taken = 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:     state <= start ? S_OPERANDS : S_IDLE;
                S_OPERANDS: state <= S_FLAGS;
                S_FLAGS:    state <= S_UPDATE;
                default:    state <= S_IDLE;
            endcase
        end
    end

    assign ctrl.sel_rd           = SEL_RD_PC_LINK;
    assign ctrl.load_rs1         = (state == S_OPERANDS);
    assign ctrl.load_rs2         = (state == S_OPERANDS);
    assign ctrl.load_imm         = (state == S_OPERANDS);
    assign ctrl.load_flags       = (state == S_FLAGS);
    assign ctrl.load_pc_alu      = (state == S_FLAGS); // jump target.
    assign ctrl.sel_alu_a        = (state == S_FLAGS) && !is_jalr; // pc based target.
    assign ctrl.load_pc          = (state == S_UPDATE);
    assign ctrl.done             = (state == S_UPDATE);
    assign ctrl.sel_pc_jump      = (state == S_UPDATE) && taken;
    assign ctrl.sel_pc_increment = (state == S_UPDATE) && !taken;
    assign ctrl.load_regfile     = (state == S_UPDATE) && is_jump; // link address.
    assign ctrl.sel_pc_next      = (state == S_UPDATE) && is_jalr;

    assign {ctrl.sub_sra, ctrl.sel_alu_b, ctrl.sel_alu_32b, ctrl.load_alu,
            ctrl.load_fp_regfile, ctrl.load_rs1_fp, ctrl.load_rs2_fp, ctrl.sel_store_fp,
            ctrl.sel_rd_fp, ctrl.start_add_sub_fp, ctrl.start_mult_fp, ctrl.load_alu_fp,
            ctrl.sub_fp, ctrl.load_data_memory, ctrl.memory_start, ctrl.sel_mem_next,
            ctrl.sel_mem_operation} = '0;

    assert property (@(posedge clk) disable iff (!arst_n) ctrl.done |=> !ctrl.done)
        else $error("fsm_branch_jump: done longer than one cycle.");

endmodule

// ==== logic/fsm_alu.sv ====
`timescale 1ns/100ps

module fsm_alu import rv_isa_pkg::*, ctrl_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,
    input  rv_insn_u insn_q,
    ctrl_if.fsm      ctrl
);
    typedef enum logic [1:0] {S_IDLE, S_OPERANDS, S_EXEC, S_WRITE} state_e;

    state_e state;
    logic   is_imm;
    logic   alt_op;

    assign is_imm = (insn_q.r.opcode == OPC_ALU_I);
    assign alt_op = insn_q.r.funct7[5] && (!is_imm || insn_q.r.funct3 == 3'b101); // srai only.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:     state <= start ? S_OPERANDS : S_IDLE;
                S_OPERANDS: state <= S_EXEC;
                S_EXEC:     state <= S_WRITE;
                default:    state <= S_IDLE;
            endcase
        end
    end

    assign ctrl.sel_rd           = SEL_RD_ALU;
    assign ctrl.load_rs1         = (state == S_OPERANDS);
    assign ctrl.load_rs2         = (state == S_OPERANDS);
    assign ctrl.load_imm         = (state == S_OPERANDS);
    assign ctrl.load_alu         = (state == S_EXEC);
    assign ctrl.sel_alu_b        = (state == S_EXEC) && is_imm;
    assign ctrl.sub_sra          = (state == S_EXEC) && alt_op;
    assign ctrl.load_regfile     = (state == S_WRITE);
    assign ctrl.load_pc          = (state == S_WRITE);
    assign ctrl.sel_pc_increment = (state == S_WRITE);
    assign ctrl.done             = (state == S_WRITE);

    assign {ctrl.sel_pc_next, ctrl.sel_alu_a, ctrl.sel_alu_32b, ctrl.load_pc_alu,
            ctrl.load_flags, ctrl.sel_pc_jump, ctrl.load_fp_regfile, ctrl.load_rs1_fp,
            ctrl.load_rs2_fp, ctrl.sel_store_fp, ctrl.sel_rd_fp, ctrl.start_add_sub_fp,
            ctrl.start_mult_fp, ctrl.load_alu_fp, ctrl.sub_fp, ctrl.load_data_memory,
            ctrl.memory_start, ctrl.sel_mem_next, ctrl.sel_mem_operation} = '0;

    assert property (@(posedge clk) disable iff (!arst_n) ctrl.done |=> !ctrl.done)
        else $error("fsm_alu: done longer than one cycle.");

endmodule

// ==== logic/insn_dispatch.sv ====
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module insn_dispatch import rv_isa_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue,
    input  rv_insn_u            insn,
    output rv_insn_u            insn_q,
    output logic [`N_UNITS-1:0] start,
    output logic                illegal_insn
);
    logic [`N_UNITS-1:0] unit_dec;

    always_comb begin
        case (insn.r.opcode)
            OPC_ALU_R, OPC_ALU_I:             unit_dec = 4'b0001;
            OPC_BRANCH, OPC_JAL, OPC_JALR:    unit_dec = 4'b0010;
            OPC_LOAD, OPC_STORE, OPC_FLW,
            OPC_FSW:                          unit_dec = 4'b0100;
            OPC_FP:                           unit_dec = 4'b1000;
            default:                          unit_dec = 4'b0000; // unknown opcode.
        endcase
    end

    always_ff @(posedge clk) begin
        if (issue)
            insn_q <= insn; // held for the FSMs until the next issue.
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start        <= '0;
            illegal_insn <= 1'b0;
        end else begin
            start        <= issue ? unit_dec : '0;
            illegal_insn <= issue && (unit_dec == '0);
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) $onehot0(start))
        else $error("insn_dispatch: more than one start strobe.");

endmodule

// ==== logic/ctrl_if.sv ====
`timescale 1ns/100ps

`include "ctrl_defs.svh"

interface ctrl_if import ctrl_pkg::*; ();
    sel_rd_e sel_rd;
    logic    sub_sra, sel_pc_next, sel_alu_a, sel_alu_b, sel_alu_32b;
    logic    load_pc_alu, load_flags, sel_pc_increment, sel_pc_jump;
    logic    load_pc, load_regfile, load_rs1, load_rs2, load_imm, load_alu;
    logic    load_fp_regfile, load_rs1_fp, load_rs2_fp, sel_store_fp, sel_rd_fp;
    logic    start_add_sub_fp, start_mult_fp, load_alu_fp, sub_fp;
    logic    load_data_memory, memory_start, sel_mem_next, sel_mem_operation;
    logic    done;

    logic [`CTRL_W-1:0] word;

    // bit order here is the output order of the combiner, done is bit 0.
    assign word = {sel_rd, sub_sra, sel_pc_next, sel_alu_a, sel_alu_b, sel_alu_32b,
                   load_pc_alu, load_flags, sel_pc_increment, sel_pc_jump,
                   load_pc, load_regfile, load_rs1, load_rs2, load_imm, load_alu,
                   load_fp_regfile, load_rs1_fp, load_rs2_fp, sel_store_fp, sel_rd_fp,
                   start_add_sub_fp, start_mult_fp, load_alu_fp, sub_fp,
                   load_data_memory, memory_start, sel_mem_next, sel_mem_operation,
                   done};

    modport fsm (
        output sel_rd, sub_sra, sel_pc_next, sel_alu_a, sel_alu_b, sel_alu_32b,
        output load_pc_alu, load_flags, sel_pc_increment, sel_pc_jump,
        output load_pc, load_regfile, load_rs1, load_rs2, load_imm, load_alu,
        output load_fp_regfile, load_rs1_fp, load_rs2_fp, sel_store_fp, sel_rd_fp,
        output start_add_sub_fp, start_mult_fp, load_alu_fp, sub_fp,
        output load_data_memory, memory_start, sel_mem_next, sel_mem_operation,
        output done
    );

    modport mux (
        input sel_rd, sub_sra, sel_pc_next, sel_alu_a, sel_alu_b, sel_alu_32b,
        input load_pc_alu, load_flags, sel_pc_increment, sel_pc_jump,
        input load_pc, load_regfile, load_rs1, load_rs2, load_imm, load_alu,
        input load_fp_regfile, load_rs1_fp, load_rs2_fp, sel_store_fp, sel_rd_fp,
        input start_add_sub_fp, start_mult_fp, load_alu_fp, sub_fp,
        input load_data_memory, memory_start, sel_mem_next, sel_mem_operation,
        input done, word
    );
endinterface

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

    // active sequencer, 0 is idle.
    typedef enum logic [2:0] {
        UNIT_IDLE   = 3'd0,
        UNIT_ALU    = 3'd1,
        UNIT_BRANCH = 3'd2,
        UNIT_MEM    = 3'd3,
        UNIT_FP     = 3'd4
    } unit_e;

    // integer register file write source.
    typedef enum logic [1:0] {
        SEL_RD_FP_MOVE = 2'b00,
        SEL_RD_MEM     = 2'b01,
        SEL_RD_ALU     = 2'b10,
        SEL_RD_PC_LINK = 2'b11
    } sel_rd_e;

endpackage

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

`include "ctrl_defs.svh"

    typedef enum logic [6:0] {
        OPC_ALU_R  = `OP_ALU_R,
        OPC_ALU_I  = `OP_ALU_I,
        OPC_BRANCH = `OP_BRANCH,
        OPC_JAL    = `OP_JAL,
        OPC_JALR   = `OP_JALR,
        OPC_LOAD   = `OP_LOAD,
        OPC_STORE  = `OP_STORE,
        OPC_FLW    = `OP_FLW,
        OPC_FSW    = `OP_FSW,
        OPC_FP     = `OP_FP
    } opcode_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_funct_e;

    typedef enum logic [6:0] {
        FP_ADD = 7'b0000000,
        FP_SUB = 7'b0000100,
        FP_MUL = 7'b0001000
    } fp_funct7_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } insn_r_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } insn_s_t;

    // same word, read as R format or as store format.
    typedef union packed {
        insn_r_t r;
        insn_s_t s;
    } rv_insn_u;

endpackage

// ==== include/ctrl_defs.svh ====
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

`define XLEN      32
`define N_UNITS   4
`define CTRL_W    31 // packed control word, sel_rd plus 29 strobes.

`define OP_ALU_R  7'b0110011
`define OP_ALU_I  7'b0010011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_FLW    7'b0000111
`define OP_FSW    7'b0100111
`define OP_FP     7'b1010011

`endif
